//--- src/bus_cmp_pkg.sv
/* Bus widths, channel structs and byte-lane types for the read-bus comparator */
`default_nettype none

package bus_cmp_pkg;

    // --------------------------------------------------
    // Bus dimensions
    // --------------------------------------------------
    localparam int unsigned ID_WIDTH         = 2;
    localparam int unsigned NUM_IDS          = 2 ** ID_WIDTH;
    localparam int unsigned ADDR_WIDTH       = 32;
    localparam int unsigned DATA_WIDTH       = 32;
    localparam int unsigned NUM_LANES        = DATA_WIDTH / 8;
    localparam int unsigned LANE_IDX_WIDTH   = $clog2(NUM_LANES);
    localparam int unsigned SIZE_WIDTH       = 3;
    localparam int unsigned LEN_WIDTH        = 8;

    // Queue sizing, lane info outlives the AR entry so it gets twice the room
    localparam int unsigned QUEUE_DEPTH      = 4;
    localparam int unsigned LANE_QUEUE_DEPTH = 2 * QUEUE_DEPTH;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [ID_WIDTH-1:0]  id_t;
    typedef logic [NUM_IDS-1:0]   id_vec_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    typedef struct packed {
        id_t                   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [SIZE_WIDTH-1:0] size;
    } ar_chan_t;

    typedef struct packed {
        id_t                   id;
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } r_chan_t;

    // Start lane of the first beat and the beat size of one read burst
    typedef struct packed {
        logic [LANE_IDX_WIDTH-1:0] offset;
        logic [SIZE_WIDTH-1:0]     size;
    } lane_info_t;

endpackage

`default_nettype wire

//--- src/cmp_fifo.sv
/* Synchronous FIFO without fall-through, head visible one cycle after push */
`timescale 1ns/1ns
`default_nettype none

module cmp_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [WIDTH-1:0] data_i,
    input  logic             push_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int unsigned PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     mem_q [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_q;
    logic [CNT_WIDTH-1:0] count_q;
    logic                 do_push;
    logic                 do_pop;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_WIDTH'(DEPTH));
    assign empty_o = (count_q == '0);

    // Push on full and pop on empty are dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/beat_fork.sv
/* Two-way valid/ready fork, remembers which branch already took the beat */
`timescale 1ns/1ns
`default_nettype none

module beat_fork (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       valid_i,
    output logic       ready_o,
    output logic [1:0] valid_o,
    input  logic [1:0] ready_i
);

    logic [1:0] sent_q;

    // A branch that has the beat is not offered it again
    assign valid_o = {2{valid_i}} & ~sent_q;

    // Source completes once every branch took it, now or before
    assign ready_o = &(ready_i | sent_q);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sent_q <= '0;
        end else if (valid_i) begin
            if (ready_o) begin
                sent_q <= '0;
            end else begin
                sent_q <= sent_q | (valid_o & ready_i);
            end
        end
    end

endmodule

`default_nettype wire

//--- src/id_queue_bank.sv
/* One FIFO per transaction ID, pushes routed by ID, per-ID heads out */
`timescale 1ns/1ns
`default_nettype none

module id_queue_bank #(
    parameter int unsigned WIDTH = 8
) (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic [WIDTH-1:0]                              entry_i,
    input  bus_cmp_pkg::id_t                              id_i,
    input  logic                                          valid_i,
    output logic                                          ready_o,
    output bus_cmp_pkg::id_vec_t                          accepted_o,
    input  bus_cmp_pkg::id_vec_t                          pop_i,
    output bus_cmp_pkg::id_vec_t                          head_valid_o,
    output logic [bus_cmp_pkg::NUM_IDS-1:0][WIDTH-1:0]    heads_o
);

    import bus_cmp_pkg::*;

    id_vec_t push;
    id_vec_t full;
    id_vec_t empty;

    // --------------------------------------------------
    // Push routing
    // --------------------------------------------------
    always_comb begin
        push          = '0;
        push[id_i]    = valid_i;
    end

    // Ready only depends on the selected queue, never on valid
    assign ready_o    = ~full[id_i];
    assign accepted_o = push & ~full;

    // --------------------------------------------------
    // Per-ID queues
    // --------------------------------------------------
    for (genvar i = 0; i < NUM_IDS; i++) begin : gen_queue
        cmp_fifo #(
            .WIDTH ( WIDTH       ),
            .DEPTH ( QUEUE_DEPTH )
        ) i_fifo (
            .clk_i,
            .rst_ni,
            .data_i  ( entry_i    ),
            .push_i  ( push[i]    ),
            .pop_i   ( pop_i[i]   ),
            .data_o  ( heads_o[i] ),
            .full_o  ( full[i]    ),
            .empty_o ( empty[i]   )
        );
    end

    assign head_valid_o = ~empty;

endmodule

`default_nettype wire

//--- src/read_lane_tracker.sv
/* Per-ID lane info queue and beat increment, gives the active byte lanes */
`timescale 1ns/1ns
`default_nettype none

module read_lane_tracker (
    input  logic                                                 clk_i,
    input  logic                                                 rst_ni,
    input  bus_cmp_pkg::ar_chan_t                                ar_i,
    input  bus_cmp_pkg::id_vec_t                                 ar_accepted_i,
    input  bus_cmp_pkg::id_vec_t                                 r_pop_i,
    input  bus_cmp_pkg::id_vec_t                                 r_last_i,
    output bus_cmp_pkg::lane_mask_t [bus_cmp_pkg::NUM_IDS-1:0]   lane_mask_o
);

    import bus_cmp_pkg::*;

    lane_info_t new_info;

    assign new_info.offset = ar_i.addr[LANE_IDX_WIDTH-1:0];
    assign new_info.size   = ar_i.size;

    for (genvar i = 0; i < NUM_IDS; i++) begin : gen_id
        lane_info_t                info;
        logic [LANE_IDX_WIDTH-1:0] incr_q;
        logic [LANE_IDX_WIDTH:0]   num_bytes;
        logic [LANE_IDX_WIDTH:0]   lower;
        logic [LANE_IDX_WIDTH:0]   upper;

        // Info leaves with the last beat of the burst
        cmp_fifo #(
            .WIDTH ( $bits(lane_info_t) ),
            .DEPTH ( LANE_QUEUE_DEPTH   )
        ) i_info_fifo (
            .clk_i,
            .rst_ni,
            .data_i  ( new_info                  ),
            .push_i  ( ar_accepted_i[i]          ),
            .pop_i   ( r_pop_i[i] & r_last_i[i]  ),
            .data_o  ( info                      ),
            .full_o  (                           ),
            .empty_o (                           )
        );

        // Sizes wider than the bus cover every lane
        assign num_bytes = (info.size >= LANE_IDX_WIDTH) ? (LANE_IDX_WIDTH+1)'(NUM_LANES)
                                                         : (LANE_IDX_WIDTH+1)'(1) << info.size;

        // Window runs from the current lane to the next size-aligned boundary
        assign lower = {1'b0, LANE_IDX_WIDTH'(info.offset + incr_q)};
        assign upper = (lower & ~(num_bytes - 1'b1)) + num_bytes;

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                incr_q <= '0;
            end else if (r_pop_i[i]) begin
                if (r_last_i[i]) begin
                    incr_q <= '0;
                end else begin
                    // Wraps into the next data word
                    incr_q <= LANE_IDX_WIDTH'(upper - {1'b0, info.offset});
                end
            end
        end

        always_comb begin
            for (int j = 0; j < NUM_LANES; j++) begin
                lane_mask_o[i][j] = (j >= lower) && (j < upper);
            end
        end
    end

endmodule

`default_nettype wire

//--- src/read_compare.sv
/* Per-ID compare of AR and R queue heads, gives pops and mismatch bits */
`timescale 1ns/1ns
`default_nettype none

module read_compare (
    input  bus_cmp_pkg::id_vec_t                                ar_head_valid_a_i,
    input  bus_cmp_pkg::id_vec_t                                ar_head_valid_b_i,
    input  bus_cmp_pkg::ar_chan_t   [bus_cmp_pkg::NUM_IDS-1:0]  ar_heads_a_i,
    input  bus_cmp_pkg::ar_chan_t   [bus_cmp_pkg::NUM_IDS-1:0]  ar_heads_b_i,
    input  bus_cmp_pkg::id_vec_t                                r_head_valid_a_i,
    input  bus_cmp_pkg::id_vec_t                                r_head_valid_b_i,
    input  bus_cmp_pkg::r_chan_t    [bus_cmp_pkg::NUM_IDS-1:0]  r_heads_a_i,
    input  bus_cmp_pkg::r_chan_t    [bus_cmp_pkg::NUM_IDS-1:0]  r_heads_b_i,
    input  bus_cmp_pkg::lane_mask_t [bus_cmp_pkg::NUM_IDS-1:0]  lane_mask_i,
    output bus_cmp_pkg::id_vec_t                                ar_pop_o,
    output bus_cmp_pkg::id_vec_t                                r_pop_o,
    output bus_cmp_pkg::id_vec_t                                ar_mismatch_o,
    output bus_cmp_pkg::id_vec_t                                r_mismatch_o
);

    import bus_cmp_pkg::*;

    // Pairs leave together as soon as both heads are present
    assign ar_pop_o = ar_head_valid_a_i & ar_head_valid_b_i;
    assign r_pop_o  = r_head_valid_a_i & r_head_valid_b_i;

    for (genvar i = 0; i < NUM_IDS; i++) begin : gen_id
        lane_mask_t lane_diff;
        logic       data_mismatch;
        logic       ctrl_mismatch;

        for (genvar j = 0; j < NUM_LANES; j++) begin : gen_lane
            assign lane_diff[j] = r_heads_a_i[i].data[8*j +: 8] != r_heads_b_i[i].data[8*j +: 8];
        end

        // Only lanes that carry this beat count
        assign data_mismatch = |(lane_diff & lane_mask_i[i]);
        assign ctrl_mismatch = (r_heads_a_i[i].id   != r_heads_b_i[i].id)   ||
                               (r_heads_a_i[i].resp != r_heads_b_i[i].resp) ||
                               (r_heads_a_i[i].last != r_heads_b_i[i].last);

        assign ar_mismatch_o[i] = ar_pop_o[i] && (ar_heads_a_i[i] != ar_heads_b_i[i]);
        assign r_mismatch_o[i]  = r_pop_o[i] && (data_mismatch || ctrl_mismatch);
    end

endmodule

`default_nettype wire

//--- src/read_bus_compare.sv
/* Read-bus comparator top, passes AR and R of buses A and B through */
/* and compares the per-ID queued copies */
`timescale 1ns/1ns
`default_nettype none

module read_bus_compare (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Bus A
    input  bus_cmp_pkg::ar_chan_t a_ar_i,
    input  logic                  a_ar_valid_i,
    output logic                  a_ar_ready_o,
    output bus_cmp_pkg::ar_chan_t a_ar_o,
    output logic                  a_ar_valid_o,
    input  logic                  a_ar_ready_i,
    input  bus_cmp_pkg::r_chan_t  a_r_i,
    input  logic                  a_r_valid_i,
    output logic                  a_r_ready_o,
    output bus_cmp_pkg::r_chan_t  a_r_o,
    output logic                  a_r_valid_o,
    input  logic                  a_r_ready_i,
    // Bus B
    input  bus_cmp_pkg::ar_chan_t b_ar_i,
    input  logic                  b_ar_valid_i,
    output logic                  b_ar_ready_o,
    output bus_cmp_pkg::ar_chan_t b_ar_o,
    output logic                  b_ar_valid_o,
    input  logic                  b_ar_ready_i,
    input  bus_cmp_pkg::r_chan_t  b_r_i,
    input  logic                  b_r_valid_i,
    output logic                  b_r_ready_o,
    output bus_cmp_pkg::r_chan_t  b_r_o,
    output logic                  b_r_valid_o,
    input  logic                  b_r_ready_i,
    // Status
    output bus_cmp_pkg::id_vec_t  ar_mismatch_o,
    output bus_cmp_pkg::id_vec_t  r_mismatch_o,
    output logic                  mismatch_o,
    output logic                  busy_o
);

    import bus_cmp_pkg::*;

    logic       ar_bank_valid_a;
    logic       ar_bank_ready_a;
    logic       ar_bank_valid_b;
    logic       ar_bank_ready_b;
    logic       r_bank_valid_a;
    logic       r_bank_ready_a;
    logic       r_bank_valid_b;
    logic       r_bank_ready_b;
    id_vec_t    ar_accepted_a;
    id_vec_t    ar_head_valid_a;
    id_vec_t    ar_head_valid_b;
    id_vec_t    r_head_valid_a;
    id_vec_t    r_head_valid_b;
    ar_chan_t   [NUM_IDS-1:0] ar_heads_a;
    ar_chan_t   [NUM_IDS-1:0] ar_heads_b;
    r_chan_t    [NUM_IDS-1:0] r_heads_a;
    r_chan_t    [NUM_IDS-1:0] r_heads_b;
    id_vec_t    ar_pop;
    id_vec_t    r_pop;
    id_vec_t    r_last_a;
    lane_mask_t [NUM_IDS-1:0] lane_mask;

    // Payloads pass straight through
    assign a_ar_o = a_ar_i;
    assign b_ar_o = b_ar_i;
    assign a_r_o  = a_r_i;
    assign b_r_o  = b_r_i;

    // --------------------------------------------------
    // Forks, bit 0 is the bus branch, bit 1 the queue
    // --------------------------------------------------
    beat_fork i_ar_fork_a (
        .clk_i, .rst_ni,
        .valid_i ( a_ar_valid_i                    ),
        .ready_o ( a_ar_ready_o                    ),
        .valid_o ( {ar_bank_valid_a, a_ar_valid_o} ),
        .ready_i ( {ar_bank_ready_a, a_ar_ready_i} )
    );

    beat_fork i_ar_fork_b (
        .clk_i, .rst_ni,
        .valid_i ( b_ar_valid_i                    ),
        .ready_o ( b_ar_ready_o                    ),
        .valid_o ( {ar_bank_valid_b, b_ar_valid_o} ),
        .ready_i ( {ar_bank_ready_b, b_ar_ready_i} )
    );

    beat_fork i_r_fork_a (
        .clk_i, .rst_ni,
        .valid_i ( a_r_valid_i                   ),
        .ready_o ( a_r_ready_o                   ),
        .valid_o ( {r_bank_valid_a, a_r_valid_o} ),
        .ready_i ( {r_bank_ready_a, a_r_ready_i} )
    );

    beat_fork i_r_fork_b (
        .clk_i, .rst_ni,
        .valid_i ( b_r_valid_i                   ),
        .ready_o ( b_r_ready_o                   ),
        .valid_o ( {r_bank_valid_b, b_r_valid_o} ),
        .ready_i ( {r_bank_ready_b, b_r_ready_i} )
    );

    // --------------------------------------------------
    // Per-ID queues
    // --------------------------------------------------
    id_queue_bank #(.WIDTH($bits(ar_chan_t))) i_ar_bank_a (
        .clk_i, .rst_ni,
        .entry_i ( a_ar_i ), .id_i ( a_ar_i.id ),
        .valid_i ( ar_bank_valid_a ), .ready_o ( ar_bank_ready_a ),
        .accepted_o ( ar_accepted_a ), .pop_i ( ar_pop ),
        .head_valid_o ( ar_head_valid_a ), .heads_o ( ar_heads_a )
    );

    id_queue_bank #(.WIDTH($bits(ar_chan_t))) i_ar_bank_b (
        .clk_i, .rst_ni,
        .entry_i ( b_ar_i ), .id_i ( b_ar_i.id ),
        .valid_i ( ar_bank_valid_b ), .ready_o ( ar_bank_ready_b ),
        .accepted_o ( ), .pop_i ( ar_pop ),
        .head_valid_o ( ar_head_valid_b ), .heads_o ( ar_heads_b )
    );

    id_queue_bank #(.WIDTH($bits(r_chan_t))) i_r_bank_a (
        .clk_i, .rst_ni,
        .entry_i ( a_r_i ), .id_i ( a_r_i.id ),
        .valid_i ( r_bank_valid_a ), .ready_o ( r_bank_ready_a ),
        .accepted_o ( ), .pop_i ( r_pop ),
        .head_valid_o ( r_head_valid_a ), .heads_o ( r_heads_a )
    );

    id_queue_bank #(.WIDTH($bits(r_chan_t))) i_r_bank_b (
        .clk_i, .rst_ni,
        .entry_i ( b_r_i ), .id_i ( b_r_i.id ),
        .valid_i ( r_bank_valid_b ), .ready_o ( r_bank_ready_b ),
        .accepted_o ( ), .pop_i ( r_pop ),
        .head_valid_o ( r_head_valid_b ), .heads_o ( r_heads_b )
    );

    // --------------------------------------------------
    // Lane tracking and compare
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_IDS; i++) begin
            r_last_a[i] = r_heads_a[i].last;
        end
    end

    // Lanes follow the bus A request
    read_lane_tracker i_lane_tracker (
        .clk_i, .rst_ni,
        .ar_i          ( a_ar_i        ),
        .ar_accepted_i ( ar_accepted_a ),
        .r_pop_i       ( r_pop         ),
        .r_last_i      ( r_last_a      ),
        .lane_mask_o   ( lane_mask     )
    );

    read_compare i_compare (
        .ar_head_valid_a_i ( ar_head_valid_a ), .ar_head_valid_b_i ( ar_head_valid_b ),
        .ar_heads_a_i      ( ar_heads_a      ), .ar_heads_b_i      ( ar_heads_b      ),
        .r_head_valid_a_i  ( r_head_valid_a  ), .r_head_valid_b_i  ( r_head_valid_b  ),
        .r_heads_a_i       ( r_heads_a       ), .r_heads_b_i       ( r_heads_b       ),
        .lane_mask_i       ( lane_mask       ),
        .ar_pop_o          ( ar_pop          ), .r_pop_o           ( r_pop           ),
        .ar_mismatch_o,
        .r_mismatch_o
    );

    assign mismatch_o = (|ar_mismatch_o) | (|r_mismatch_o);
    assign busy_o     = |{ar_head_valid_a, ar_head_valid_b, r_head_valid_a, r_head_valid_b};

endmodule

`default_nettype wire

//--- testbench/tb_read_bus_compare.sv
/* Directed testbench for the read-bus comparator,
   AR and R stimulus on both buses, mismatch monitor, watchdog */
`timescale 1ns/1ns
`default_nettype none

module tb_read_bus_compare;

    import bus_cmp_pkg::*;

    localparam int unsigned CLK_PERIOD  = 100;
    localparam int unsigned IDLE_LIMIT  = 20;
    // Reset plus seven test runs of at most about 60 cycles each
    localparam int unsigned TEST_CYCLES = 10 + 7 * 60;
    localparam int unsigned TIMEOUT_NS  = TEST_CYCLES * CLK_PERIOD * 2;

    // Size 0 at lane offset 1 touches lane 1 only
    localparam lane_mask_t NARROW_LANES = 4'b0010;

    logic     clk_i;
    logic     rst_ni;
    ar_chan_t a_ar_i, a_ar_o, b_ar_i, b_ar_o;
    logic     a_ar_valid_i, a_ar_ready_o, a_ar_valid_o, a_ar_ready_i;
    logic     b_ar_valid_i, b_ar_ready_o, b_ar_valid_o, b_ar_ready_i;
    r_chan_t  a_r_i, a_r_o, b_r_i, b_r_o;
    logic     a_r_valid_i, a_r_ready_o, a_r_valid_o, a_r_ready_i;
    logic     b_r_valid_i, b_r_ready_o, b_r_valid_o, b_r_ready_i;
    id_vec_t  ar_mismatch_o;
    id_vec_t  r_mismatch_o;
    logic     mismatch_o;
    logic     busy_o;

    // Sticky record of mismatch bits since the last clear
    id_vec_t  seen_ar;
    id_vec_t  seen_r;
    logic     seen_any;
    integer   seed;

    read_bus_compare read_bus_compare_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failures found");
        $fatal(1);
    end

    always @(posedge clk_i) begin
        seen_ar  <= seen_ar | ar_mismatch_o;
        seen_r   <= seen_r | r_mismatch_o;
        seen_any <= seen_any | mismatch_o;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    function automatic ar_chan_t make_ar(input id_t id, input logic [31:0] addr,
                                         input logic [7:0] len, input logic [2:0] size);
        ar_chan_t ar;
        ar.id   = id;
        ar.addr = addr;
        ar.len  = len;
        ar.size = size;
        return ar;
    endfunction

    function automatic r_chan_t make_r(input id_t id, input logic [31:0] data,
                                       input logic [1:0] resp, input logic last);
        r_chan_t r;
        r.id   = id;
        r.data = data;
        r.resp = resp;
        r.last = last;
        return r;
    endfunction

    task automatic send_ar(input logic bus_b, input ar_chan_t ar);
        logic done;
        logic first;
        done  = 1'b0;
        first = 1'b1;
        @(negedge clk_i);
        if (bus_b) begin
            b_ar_i       = ar;
            b_ar_valid_i = 1'b1;
        end else begin
            a_ar_i       = ar;
            a_ar_valid_i = 1'b1;
        end
        while (!done) begin
            @(posedge clk_i);
            // Request reaches the subordinate unchanged in its first cycle
            if (first) begin
                check("ar pass-through payload", ar, bus_b ? b_ar_o : a_ar_o);
                check("ar pass-through valid", 1, bus_b ? b_ar_valid_o : a_ar_valid_o);
                first = 1'b0;
            end
            done = bus_b ? b_ar_ready_o : a_ar_ready_o;
        end
        @(negedge clk_i);
        a_ar_valid_i = 1'b0;
        b_ar_valid_i = 1'b0;
    endtask

    task automatic send_r(input logic bus_b, input r_chan_t r);
        logic done;
        logic first;
        done  = 1'b0;
        first = 1'b1;
        @(negedge clk_i);
        if (bus_b) begin
            b_r_i       = r;
            b_r_valid_i = 1'b1;
        end else begin
            a_r_i       = r;
            a_r_valid_i = 1'b1;
        end
        while (!done) begin
            @(posedge clk_i);
            // Beat reaches the manager unchanged in its first cycle
            if (first) begin
                check("r pass-through payload", r, bus_b ? b_r_o : a_r_o);
                check("r pass-through valid", 1, bus_b ? b_r_valid_o : a_r_valid_o);
                first = 1'b0;
            end
            done = bus_b ? b_r_ready_o : a_r_ready_o;
        end
        @(negedge clk_i);
        a_r_valid_i = 1'b0;
        b_r_valid_i = 1'b0;
    endtask

    task automatic clear_seen();
        @(negedge clk_i);
        seen_ar  = '0;
        seen_r   = '0;
        seen_any = 1'b0;
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (busy_o && cycles < IDLE_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (busy_o) begin
            $display("%s: busy_o stayed high, queued entries were never compared", name);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_seen(input string name, input id_vec_t exp_ar, input id_vec_t exp_r);
        check({name, " ar_mismatch_o"}, exp_ar, seen_ar);
        check({name, " r_mismatch_o"}, exp_r, seen_r);
        check({name, " mismatch_o"}, (exp_ar != '0) || (exp_r != '0), seen_any);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_equal_read();
        logic [31:0] data;
        data = $random(seed);
        clear_seen();
        send_ar(1'b0, make_ar(2'd0, 32'h100, 8'd0, 3'd2));
        send_ar(1'b1, make_ar(2'd0, 32'h100, 8'd0, 3'd2));
        send_r(1'b0, make_r(2'd0, data, 2'b00, 1'b1));
        send_r(1'b1, make_r(2'd0, data, 2'b00, 1'b1));
        wait_idle("equal_read");
        check_seen("equal_read", 4'b0000, 4'b0000);
    endtask

    task automatic test_ar_addr_diff();
        clear_seen();
        send_ar(1'b0, make_ar(2'd1, 32'h180, 8'd0, 3'd2));
        send_ar(1'b1, make_ar(2'd1, 32'h184, 8'd0, 3'd2));
        wait_idle("ar_addr_diff");
        check_seen("ar_addr_diff", 4'b0010, 4'b0000);
    endtask

    task automatic narrow_beat(input lane_mask_t diff_lanes, input logic [31:0] diff_bits);
        logic [31:0] data;
        id_vec_t     exp_r;
        data  = $random(seed);
        exp_r = (|(diff_lanes & NARROW_LANES)) ? 4'b0100 : 4'b0000;
        clear_seen();
        send_ar(1'b0, make_ar(2'd2, 32'h201, 8'd0, 3'd0));
        send_ar(1'b1, make_ar(2'd2, 32'h201, 8'd0, 3'd0));
        send_r(1'b0, make_r(2'd2, data, 2'b00, 1'b1));
        send_r(1'b1, make_r(2'd2, data ^ diff_bits, 2'b00, 1'b1));
        wait_idle("narrow_read");
        check_seen("narrow_read", 4'b0000, exp_r);
    endtask

    task automatic test_burst_resp_diff();
        logic [31:0] beat_data [4];
        for (int i = 0; i < 4; i++) begin
            beat_data[i] = $random(seed);
        end
        clear_seen();
        send_ar(1'b0, make_ar(2'd3, 32'h300, 8'd3, 3'd2));
        send_ar(1'b1, make_ar(2'd3, 32'h300, 8'd3, 3'd2));
        for (int i = 0; i < 4; i++) begin
            send_r(1'b0, make_r(2'd3, beat_data[i], 2'b00, i == 3));
        end
        // Last beat of bus B answers with SLVERR
        for (int i = 0; i < 4; i++) begin
            send_r(1'b1, make_r(2'd3, beat_data[i], (i == 3) ? 2'b10 : 2'b00, i == 3));
        end
        wait_idle("burst_resp_diff");
        check_seen("burst_resp_diff", 4'b0000, 4'b1000);
    endtask

    task automatic test_id_reorder();
        clear_seen();
        send_ar(1'b0, make_ar(2'd1, 32'h110, 8'd0, 3'd2));
        send_ar(1'b0, make_ar(2'd2, 32'h120, 8'd0, 3'd2));
        send_ar(1'b1, make_ar(2'd2, 32'h120, 8'd0, 3'd2));
        send_ar(1'b1, make_ar(2'd1, 32'h110, 8'd0, 3'd2));
        wait_idle("id_reorder");
        check_seen("id_reorder", 4'b0000, 4'b0000);
    endtask

    task automatic test_ar_stall();
        logic done;
        done = 1'b0;
        clear_seen();
        @(negedge clk_i);
        a_ar_ready_i = 1'b0;
        a_ar_i       = make_ar(2'd0, 32'h600, 8'd0, 3'd2);
        a_ar_valid_i = 1'b1;
        repeat (3) @(negedge clk_i);
        check("ar_stall a_ar_valid_o", 1, a_ar_valid_o);
        check("ar_stall a_ar_ready_o", 0, a_ar_ready_o);
        a_ar_ready_i = 1'b1;
        while (!done) begin
            @(posedge clk_i);
            done = a_ar_ready_o;
        end
        @(negedge clk_i);
        a_ar_valid_i = 1'b0;
        send_ar(1'b1, make_ar(2'd0, 32'h600, 8'd0, 3'd2));
        // A second queued copy on bus A would keep busy_o high
        wait_idle("ar_stall");
        check_seen("ar_stall", 4'b0000, 4'b0000);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        seed         = 73;
        rst_ni       = 1'b0;
        a_ar_i       = '0;
        b_ar_i       = '0;
        a_r_i        = '0;
        b_r_i        = '0;
        a_ar_valid_i = 1'b0;
        b_ar_valid_i = 1'b0;
        a_r_valid_i  = 1'b0;
        b_r_valid_i  = 1'b0;
        a_ar_ready_i = 1'b1;
        b_ar_ready_i = 1'b1;
        a_r_ready_i  = 1'b1;
        b_r_ready_i  = 1'b1;
        seen_ar      = '0;
        seen_r       = '0;
        seen_any     = 1'b0;

        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        test_equal_read();
        test_ar_addr_diff();
        narrow_beat(4'b0001, 32'h0000_00ff);
        narrow_beat(4'b0010, 32'h0000_ff00);
        test_burst_resp_diff();
        test_id_reorder();
        test_ar_stall();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/bus_cmp_pkg.sv
src/cmp_fifo.sv
src/beat_fork.sv
src/id_queue_bank.sv
src/read_lane_tracker.sv
src/read_compare.sv
src/read_bus_compare.sv
testbench/tb_read_bus_compare.sv

//--- Bender.yml
package:
  name: read_bus_compare

sources:
  - src/bus_cmp_pkg.sv
  - src/cmp_fifo.sv
  - src/beat_fork.sv
  - src/id_queue_bank.sv
  - src/read_lane_tracker.sv
  - src/read_compare.sv
  - src/read_bus_compare.sv
  - target: test
    files:
      - testbench/tb_read_bus_compare.sv
